// ==== bench/tb_mini_mcu_power.sv ====
//****************************************************************************
// testbench for the power and interrupt block: clock, reset, switch model,
// reference vector, sequence checks and run limit
//****************************************************************************

`timescale 1ns/10ps
`include "mini_mcu_power_consts.svh"

module tb_mini_mcu_power
  import mini_mcu_power_pkg::*;
;

  logic clk_i, rst_n_i, debug_reset_n_i, core_sleep_i, periph_off_req_i;
  logic irq_software_i, irq_external_i, rv_timer0_i;
  fast_irq_t fast_irq_i;
  logic [`MEM_BANKS-1:0] bank_ret_req_i, bank_iso_n_o, bank_retentive_n_o, bank_clkgate_n_o;
  logic cpu_switch_ack_n_i, periph_switch_ack_n_i;
  logic cpu_switch_n_o, cpu_iso_n_o, cpu_rst_n_o;
  logic periph_switch_n_o, periph_iso_n_o, periph_rst_n_o, periph_clkgate_n_o;
  logic [`INTR_W-1:0] intr_o;
  logic [`INTR_W-1:0] exp_intr;
  logic [1:0] cpu_sw_pipe, periph_sw_pipe;
  logic [31:0] rnd;
  int errors;
  int cycles;

  mini_mcu_power uut (.*);

  always #50 clk_i = ~clk_i;

  // switch cells answer 3 cycles after their switch pin
  always @(posedge clk_i) begin
    cpu_sw_pipe <= {cpu_sw_pipe[0], cpu_switch_n_o};
    periph_sw_pipe <= {periph_sw_pipe[0], periph_switch_n_o};
    cpu_switch_ack_n_i <= cpu_sw_pipe[1];
    periph_switch_ack_n_i <= periph_sw_pipe[1];
  end

  // whole run is a few hundred cycles
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 2000) begin
      $display("timeout: the run did not finish within 2000 cycles");
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [`INTR_W-1:0] ref_intr(logic sw, logic ext, logic tmr, fast_irq_t f);
    logic [`INTR_W-1:0] v;
    v = '0;
    v[`IRQ_SW_BIT] = sw;
    v[`IRQ_TIMER_BIT] = tmr;
    v[`IRQ_EXT_BIT] = ext;
    v[`IRQ_FAST_LSB +: 15] = f;
    return v;
  endfunction

  // expected vector follows the sources by one cycle
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_intr <= '0;
    end else begin
      exp_intr <= ref_intr(irq_software_i, irq_external_i, rv_timer0_i, fast_irq_i);
    end
  end

  always @(negedge clk_i) begin
    if (intr_o !== exp_intr) begin
      errors++;
      $display("mismatch intr_o: got %h expected %h", intr_o, exp_intr);
    end
  end

  // pins per domain as {switch, reset, iso, clkgate} with unseen pins read as 1
  function automatic logic [3:0] get_pins(int d);
    if (d == 0) return {cpu_switch_n_o, cpu_rst_n_o, cpu_iso_n_o, 1'b1};
    if (d == 1) return {periph_switch_n_o, periph_rst_n_o, periph_iso_n_o, periph_clkgate_n_o};
    return {bank_retentive_n_o[d-2], 1'b1, bank_iso_n_o[d-2], bank_clkgate_n_o[d-2]};
  endfunction

  function automatic logic [3:0] vis_mask(int d);
    return (d == 0) ? 4'b1110 : (d == 1) ? 4'b1111 : 4'b1011;
  endfunction

  // pins k cycles into power-down
  function automatic logic [3:0] exp_down(int k);
    return {k < 4, k < 3, k < 2, k < 1};
  endfunction

  function automatic pwr_state_e get_state(int d);
    if (d == 0) return uut.cpu_seq_i.state_q;
    if (d == 1) return uut.periph_seq_i.state_q;
    if (d == 2) return uut.gen_bank_seq[0].bank_seq_i.state_q;
    return uut.gen_bank_seq[1].bank_seq_i.state_q;
  endfunction

  function automatic logic ack_pin(int d);
    return (d == 0) ? cpu_switch_ack_n_i : (d == 1) ? periph_switch_ack_n_i : 1'b1;
  endfunction

  task automatic set_req(int d, logic val);
    @(posedge clk_i);
    if (d == 0 && val) core_sleep_i <= 1'b1;
    else if (d == 0) rv_timer0_i <= 1'b1;
    else if (d == 1) periph_off_req_i <= val;
    else bank_ret_req_i[d-2] <= val;
  endtask

  task automatic check_others(int d);
    for (int o = 0; o < 4; o++) begin
      if (o != d && get_pins(o) !== 4'hf) begin
        errors++;
        $display("mismatch domain %0d pins: got %h expected %h", o, get_pins(o), 4'hf);
      end
    end
  endtask

  task automatic down_seq(int d);
    logic [3:0] m;
    pwr_state_e st;
    m = vis_mask(d);
    for (int k = 0; k <= 4; k++) begin
      @(negedge clk_i);
      if ((get_pins(d) & m) !== (exp_down(k) & m)) begin
        errors++;
        $display("mismatch domain %0d pins: got %h expected %h", d, get_pins(d) & m,
                 exp_down(k) & m);
      end
      if (d >= 2) check_others(d);
    end
    for (int w = 0; w < 30 && get_state(d) != PWR_OFF; w++) @(negedge clk_i);
    st = get_state(d);
    if (st != PWR_OFF) begin
      errors++;
      $display("domain %0d never reached the off state, stuck in %s", d, st.name());
    end else if (d < 2 && ack_pin(d)) begin
      errors++;
      $display("domain %0d reached the off state before its acknowledge fell", d);
    end
  endtask

  task automatic up_seq(int d);
    logic [3:0] m;
    int prev_k, k, ack_cnt;
    pwr_state_e st;
    m = vis_mask(d);
    prev_k = 4;
    ack_cnt = 0;
    for (int w = 0; w < 40 && !(get_state(d) == PWR_ON && prev_k == 0); w++) begin
      @(negedge clk_i);
      k = -1;
      for (int j = 4; j >= 0; j--) begin
        if ((get_pins(d) & m) === (exp_down(j) & m)) k = j;
      end
      if (k < 0 || k > prev_k) begin
        errors++;
        $display("domain %0d pins %h came up out of order", d, get_pins(d));
      end else begin
        if (d < 2 && k <= 2 && prev_k > 2 && ack_cnt < 2) begin
          errors++;
          $display("domain %0d left reset before its acknowledge was high 2 cycles", d);
        end
        prev_k = k;
      end
      if (d >= 2) check_others(d);
      // count only the cycles before the current sample
      if (ack_pin(d) && d < 2) ack_cnt++;
    end
    st = get_state(d);
    if (st != PWR_ON) begin
      errors++;
      $display("domain %0d did not power up, stuck in %s", d, st.name());
    end
  endtask

  initial begin
    logic [`MEM_BANKS-1:0] bank_iso_save, bank_ret_save, bank_clk_save;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    debug_reset_n_i = 1'b1;
    core_sleep_i = 1'b0;
    periph_off_req_i = 1'b0;
    bank_ret_req_i = '0;
    irq_software_i = 1'b0;
    irq_external_i = 1'b0;
    rv_timer0_i = 1'b0;
    fast_irq_i = '0;
    cpu_switch_ack_n_i = 1'b1;
    periph_switch_ack_n_i = 1'b1;
    cpu_sw_pipe = '1;
    periph_sw_pipe = '1;
    rnd = 32'h3cb0;
    errors = 0;
    cycles = 0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    for (int d = 0; d < 4; d++) begin
      if (get_pins(d) !== 4'hf) begin
        errors++;
        $display("mismatch domain %0d pins after reset: got %h expected %h",
                 d, get_pins(d), 4'hf);
      end
    end
    // random sources checked by the compare process
    for (int i = 0; i < 40; i++) begin
      @(posedge clk_i);
      rnd = xorshift(rnd);
      irq_software_i <= rnd[0];
      irq_external_i <= rnd[1];
      rv_timer0_i <= rnd[2];
      fast_irq_i <= rnd[17:3];
    end
    @(posedge clk_i);
    irq_software_i <= 1'b0;
    irq_external_i <= 1'b0;
    rv_timer0_i <= 1'b0;
    fast_irq_i <= '0;
    repeat (2) @(posedge clk_i);
    // cpu sleep and wake by the timer
    set_req(0, 1'b1);
    down_seq(0);
    set_req(0, 1'b0);
    up_seq(0);
    @(posedge clk_i);
    core_sleep_i <= 1'b0;
    rv_timer0_i <= 1'b0;
    set_req(1, 1'b1);
    down_seq(1);
    set_req(1, 1'b0);
    up_seq(1);
    set_req(2, 1'b1);
    down_seq(2);
    // debug reset pulse with bank 0 held in retention
    bank_iso_save = bank_iso_n_o;
    bank_ret_save = bank_retentive_n_o;
    bank_clk_save = bank_clkgate_n_o;
    @(posedge clk_i);
    debug_reset_n_i <= 1'b0;
    @(negedge clk_i);
    if (cpu_rst_n_o !== 1'b0 || periph_rst_n_o !== 1'b0) begin
      errors++;
      $display("mismatch {cpu_rst_n_o, periph_rst_n_o}: got %h expected %h",
               {cpu_rst_n_o, periph_rst_n_o}, 2'b00);
    end
    if ({bank_iso_n_o, bank_retentive_n_o, bank_clkgate_n_o} !==
        {bank_iso_save, bank_ret_save, bank_clk_save}) begin
      errors++;
      $display("bank pins changed during the debug reset pulse");
    end
    @(posedge clk_i);
    debug_reset_n_i <= 1'b1;
    @(negedge clk_i);
    if (cpu_rst_n_o !== 1'b1 || periph_rst_n_o !== 1'b1) begin
      errors++;
      $display("mismatch {cpu_rst_n_o, periph_rst_n_o}: got %h expected %h",
               {cpu_rst_n_o, periph_rst_n_o}, 2'b11);
    end
    set_req(2, 1'b0);
    up_seq(2);
    set_req(3, 1'b1);
    down_seq(3);
    set_req(3, 1'b0);
    up_seq(3);
    repeat (3) @(negedge clk_i);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== mini_mcu_power.f ====
+incdir+verilog
verilog/mini_mcu_power_pkg.sv
verilog/irq_collector.sv
verilog/pwr_domain_seq.sv
verilog/pwr_pad_stage.sv
verilog/mini_mcu_power.sv
bench/tb_mini_mcu_power.sv

// ==== verilog/irq_collector.sv ====
//****************************************************************************
// interrupt vector assembly and cpu sleep request
//****************************************************************************

`timescale 1ns/10ps
`include "mini_mcu_power_consts.svh"

module irq_collector
  import mini_mcu_power_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               irq_software_i,
  input  logic               irq_external_i,
  input  logic               rv_timer0_i,
  input  fast_irq_t          fast_irq_i,
  input  logic               core_sleep_i,
  output logic [`INTR_W-1:0] intr_o,
  output logic               cpu_off_req_o
);

  logic [`INTR_W-1:0] intr_d;
  logic [`INTR_W-1:0] intr_q;

  always_comb begin
    intr_d = '0;
    intr_d[`IRQ_SW_BIT] = irq_software_i;
    intr_d[`IRQ_TIMER_BIT] = rv_timer0_i;
    intr_d[`IRQ_EXT_BIT] = irq_external_i;
    intr_d[`IRQ_FAST_LSB +: $bits(fast_irq_t)] = fast_irq_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= intr_d;
    end
  end

  assign intr_o = intr_q;

  // sleep only with nothing pending
  assign cpu_off_req_o = core_sleep_i && (intr_q == '0);

  // a source seen last cycle always blocks the sleep request now
  a_no_sleep_on_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(rst_n_i) && $past(|intr_d)) |-> !cpu_off_req_o);

endmodule

// ==== verilog/mini_mcu_power.sv ====
//****************************************************************************
// power management and interrupt gathering top level
//****************************************************************************

`timescale 1ns/10ps
`include "mini_mcu_power_consts.svh"

module mini_mcu_power
  import mini_mcu_power_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  debug_reset_n_i,
  input  logic                  irq_software_i,
  input  logic                  irq_external_i,
  input  logic                  rv_timer0_i,
  input  fast_irq_t             fast_irq_i,
  input  logic                  core_sleep_i,
  output logic [`INTR_W-1:0]    intr_o,
  input  logic                  periph_off_req_i,
  input  logic [`MEM_BANKS-1:0] bank_ret_req_i,
  input  logic                  cpu_switch_ack_n_i,
  input  logic                  periph_switch_ack_n_i,
  output logic                  cpu_switch_n_o,
  output logic                  cpu_iso_n_o,
  output logic                  cpu_rst_n_o,
  output logic                  periph_switch_n_o,
  output logic                  periph_iso_n_o,
  output logic                  periph_rst_n_o,
  output logic                  periph_clkgate_n_o,
  output logic [`MEM_BANKS-1:0] bank_iso_n_o,
  output logic [`MEM_BANKS-1:0] bank_retentive_n_o,
  output logic [`MEM_BANKS-1:0] bank_clkgate_n_o
);

  logic                        cpu_off_req;
  logic                        cpu_ack_n;
  logic                        periph_ack_n;
  pwr_ctrl_t                   cpu_ctrl;
  pwr_ctrl_t                   periph_ctrl;
  pwr_ctrl_t [`MEM_BANKS-1:0]  bank_ctrl;

  irq_collector irq_collector_i (
    .clk_i,
    .rst_n_i,
    .irq_software_i,
    .irq_external_i,
    .rv_timer0_i,
    .fast_irq_i,
    .core_sleep_i,
    .intr_o,
    .cpu_off_req_o(cpu_off_req)
  );

  pwr_domain_seq #(.RETENTIVE(1'b0)) cpu_seq_i (
    .clk_i,
    .rst_n_i,
    .off_req_i(cpu_off_req),
    .ack_n_i  (cpu_ack_n),
    .ctrl_o   (cpu_ctrl)
  );

  pwr_domain_seq #(.RETENTIVE(1'b0)) periph_seq_i (
    .clk_i,
    .rst_n_i,
    .off_req_i(periph_off_req_i),
    .ack_n_i  (periph_ack_n),
    .ctrl_o   (periph_ctrl)
  );

  // banks have no switch, ack tied inactive
  for (genvar b = 0; b < `MEM_BANKS; b++) begin : gen_bank_seq
    pwr_domain_seq #(.RETENTIVE(1'b1)) bank_seq_i (
      .clk_i,
      .rst_n_i,
      .off_req_i(bank_ret_req_i[b]),
      .ack_n_i  (1'b1),
      .ctrl_o   (bank_ctrl[b])
    );
  end

  pwr_pad_stage pwr_pad_stage_i (
    .clk_i,
    .rst_n_i,
    .debug_reset_n_i,
    .cpu_ctrl_i    (cpu_ctrl),
    .periph_ctrl_i (periph_ctrl),
    .bank_ctrl_i   (bank_ctrl),
    .cpu_switch_ack_n_i,
    .periph_switch_ack_n_i,
    .cpu_ack_n_o   (cpu_ack_n),
    .periph_ack_n_o(periph_ack_n),
    .cpu_switch_n_o,
    .cpu_iso_n_o,
    .cpu_rst_n_o,
    .periph_switch_n_o,
    .periph_iso_n_o,
    .periph_rst_n_o,
    .periph_clkgate_n_o,
    .bank_iso_n_o,
    .bank_retentive_n_o,
    .bank_clkgate_n_o
  );

endmodule

// ==== verilog/mini_mcu_power_consts.svh ====
//****************************************************************************
// sizes, interrupt bit positions and synchronizer depth
// for the power and interrupt block
//****************************************************************************

`ifndef MINI_MCU_POWER_CONSTS_SVH
`define MINI_MCU_POWER_CONSTS_SVH

// memory banks with retention
`define MEM_BANKS 2

// core interrupt vector
`define INTR_W 32

// positions in the core interrupt vector
`define IRQ_SW_BIT 3
`define IRQ_TIMER_BIT 7
`define IRQ_EXT_BIT 11
`define IRQ_FAST_LSB 16

// flops on each switch acknowledge
`define ACK_SYNC_STAGES 2

`endif

// ==== verilog/mini_mcu_power_pkg.sv ====
//****************************************************************************
// types for the power and interrupt block: fast interrupt struct,
// domain power control struct and sequencer states
//****************************************************************************

package mini_mcu_power_pkg;

  // fast sources, msb first
  typedef struct packed {
    logic       dma_window;
    logic [7:0] gpio_ao;
    logic       spi_flash;
    logic       spi;
    logic       dma_done;
    logic       timer3;
    logic       timer2;
    logic       timer1;
  } fast_irq_t;

  // all active low, all ones means domain fully on
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_t;

  typedef enum logic [3:0] {
    PWR_ON, PWR_CLK_OFF, PWR_ISO_ON, PWR_RST_ON,
    PWR_SW_OFF, PWR_WAIT_OFF, PWR_OFF, PWR_SW_ON,
    PWR_WAIT_ON, PWR_RST_OFF, PWR_ISO_OFF
  } pwr_state_e;

endpackage

// ==== verilog/pwr_domain_seq.sv ====
//****************************************************************************
// power-down and power-up sequencer for one domain,
// power switch or retention flavour
//****************************************************************************

`timescale 1ns/10ps

module pwr_domain_seq
  import mini_mcu_power_pkg::*;
#(
  parameter bit RETENTIVE = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      off_req_i,
  input  logic      ack_n_i,
  output pwr_ctrl_t ctrl_o
);

  pwr_state_e state_q;
  pwr_state_e state_d;
  pwr_ctrl_t  ctrl_q;

  // control levels held in each state
  function automatic pwr_ctrl_t decode_ctrl(pwr_state_e st);
    pwr_ctrl_t c;
    c = '1;
    if (st != PWR_ON) begin
      c.clkgate_en_n = 1'b0;
    end
    if (st inside {PWR_ISO_ON, PWR_RST_ON, PWR_SW_OFF, PWR_WAIT_OFF, PWR_OFF,
                   PWR_SW_ON, PWR_WAIT_ON, PWR_RST_OFF}) begin
      c.isogate_en_n = 1'b0;
    end
    if (st inside {PWR_RST_ON, PWR_SW_OFF, PWR_WAIT_OFF, PWR_OFF,
                   PWR_SW_ON, PWR_WAIT_ON}) begin
      c.rst_n = 1'b0;
    end
    if (st inside {PWR_SW_OFF, PWR_WAIT_OFF, PWR_OFF}) begin
      if (RETENTIVE) begin
        c.retentive_en_n = 1'b0;
      end else begin
        c.pwrgate_en_n = 1'b0;
      end
    end
    return c;
  endfunction

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ON: begin
        if (off_req_i) begin
          state_d = PWR_CLK_OFF;
        end
      end
      PWR_CLK_OFF: state_d = PWR_ISO_ON;
      PWR_ISO_ON:  state_d = PWR_RST_ON;
      PWR_RST_ON: begin
        // banks go straight to retention
        if (RETENTIVE) begin
          state_d = PWR_OFF;
        end else begin
          state_d = PWR_SW_OFF;
        end
      end
      PWR_SW_OFF: state_d = PWR_WAIT_OFF;
      PWR_WAIT_OFF: begin
        if (!ack_n_i) begin
          state_d = PWR_OFF;
        end
      end
      PWR_OFF: begin
        if (!off_req_i) begin
          state_d = PWR_SW_ON;
        end
      end
      PWR_SW_ON: begin
        if (RETENTIVE) begin
          state_d = PWR_RST_OFF;
        end else begin
          state_d = PWR_WAIT_ON;
        end
      end
      PWR_WAIT_ON: begin
        if (ack_n_i) begin
          state_d = PWR_RST_OFF;
        end
      end
      PWR_RST_OFF: state_d = PWR_ISO_OFF;
      PWR_ISO_OFF: state_d = PWR_ON;
      default:     state_d = PWR_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= PWR_ON;
      ctrl_q  <= '1;
    end else begin
      state_q <= state_d;
      ctrl_q  <= decode_ctrl(state_d);
    end
  end

  assign ctrl_o = ctrl_q;

  a_off_isolated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!ctrl_q.pwrgate_en_n || !ctrl_q.retentive_en_n) |-> (!ctrl_q.isogate_en_n && !ctrl_q.rst_n));
  a_rst_needs_power: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_q.rst_n |-> ctrl_q.pwrgate_en_n);

endmodule

// ==== verilog/pwr_pad_stage.sv ====
//****************************************************************************
// switch acknowledge synchronizers and pad-level power control pins
//****************************************************************************

`timescale 1ns/10ps
`include "mini_mcu_power_consts.svh"

module pwr_pad_stage
  import mini_mcu_power_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             debug_reset_n_i,
  input  pwr_ctrl_t                        cpu_ctrl_i,
  input  pwr_ctrl_t                        periph_ctrl_i,
  input  pwr_ctrl_t [`MEM_BANKS-1:0]       bank_ctrl_i,
  input  logic                             cpu_switch_ack_n_i,
  input  logic                             periph_switch_ack_n_i,
  output logic                             cpu_ack_n_o,
  output logic                             periph_ack_n_o,
  output logic                             cpu_switch_n_o,
  output logic                             cpu_iso_n_o,
  output logic                             cpu_rst_n_o,
  output logic                             periph_switch_n_o,
  output logic                             periph_iso_n_o,
  output logic                             periph_rst_n_o,
  output logic                             periph_clkgate_n_o,
  output logic [`MEM_BANKS-1:0]            bank_iso_n_o,
  output logic [`MEM_BANKS-1:0]            bank_retentive_n_o,
  output logic [`MEM_BANKS-1:0]            bank_clkgate_n_o
);

  // bit 1 cpu, bit 0 peripheral
  logic [`ACK_SYNC_STAGES-1:0][1:0] ack_sync_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_sync_q <= '1;
    end else begin
      ack_sync_q <= {ack_sync_q[`ACK_SYNC_STAGES-2:0], {cpu_switch_ack_n_i, periph_switch_ack_n_i}};
    end
  end

  assign cpu_ack_n_o    = ack_sync_q[`ACK_SYNC_STAGES-1][1];
  assign periph_ack_n_o = ack_sync_q[`ACK_SYNC_STAGES-1][0];

  assign cpu_switch_n_o = cpu_ctrl_i.pwrgate_en_n;
  assign cpu_iso_n_o    = cpu_ctrl_i.isogate_en_n;
  // debug reset also holds the subsystems
  assign cpu_rst_n_o    = cpu_ctrl_i.rst_n & debug_reset_n_i;

  assign periph_switch_n_o  = periph_ctrl_i.pwrgate_en_n;
  assign periph_iso_n_o     = periph_ctrl_i.isogate_en_n;
  assign periph_rst_n_o     = periph_ctrl_i.rst_n & debug_reset_n_i;
  assign periph_clkgate_n_o = periph_ctrl_i.clkgate_en_n;

  for (genvar b = 0; b < `MEM_BANKS; b++) begin : gen_bank_pins
    assign bank_iso_n_o[b]       = bank_ctrl_i[b].isogate_en_n;
    assign bank_retentive_n_o[b] = bank_ctrl_i[b].retentive_en_n;
    assign bank_clkgate_n_o[b]   = bank_ctrl_i[b].clkgate_en_n;
  end

endmodule
